/* src/axi_fabric_pkg.sv */
`default_nettype none

package axi_fabric_pkg;

    // Manager port widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    // Window geometry
    localparam int SRAM_OFFS_W = 12;
    localparam int FIFO_OFFS_W = 8;

    // 0x0001_0000, 4 KB
    localparam logic [ADDR_W-SRAM_OFFS_W-1:0] SRAM_BASE_TAG = 20'h0_0010;
    // 0x0002_0000, fixed address
    localparam logic [ADDR_W-FIFO_OFFS_W-1:0] FIFO_BASE_TAG = 24'h00_0200;

    localparam int FIFO_DEPTH      = 16;
    localparam int MAX_OUTSTANDING = 2;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // AXI burst codes
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    typedef struct packed {
        logic [ADDR_W-SRAM_OFFS_W-1:0] tag;
        logic [SRAM_OFFS_W-1:0]        offs;
    } sram_addr_t;

    typedef struct packed {
        logic [ADDR_W-FIFO_OFFS_W-1:0] tag;
        logic [FIFO_OFFS_W-1:0]        offs;
    } fifo_addr_t;

    // Same address word, split per endpoint window
    typedef union packed {
        sram_addr_t sram;
        fifo_addr_t fifo;
    } axi_addr_u;

    typedef struct packed {
        logic [ID_W-1:0]  id;
        axi_addr_u        addr;
        logic [LEN_W-1:0] len;
        logic [1:0]       burst;
    } axi_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        logic [1:0]        resp;
        logic              last;
    } axi_r_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_resp_t;

endpackage

`default_nettype wire

/* src/dma_txn_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

module dma_txn_tracker import axi_fabric_pkg::*; (
    input  logic     core_clk,
    input  logic     cptra_rst_b,
    input  logic     push,
    input  axi_cmd_t cmd_in,
    input  logic     pop,
    output axi_cmd_t head,
    output logic     busy,
    output logic     full
);

    axi_cmd_t q [MAX_OUTSTANDING];

    logic [$clog2(MAX_OUTSTANDING)-1:0] wr_ptr;
    logic [$clog2(MAX_OUTSTANDING)-1:0] rd_ptr;
    logic [$clog2(MAX_OUTSTANDING):0]   count;

    assign head = q[rd_ptr];
    assign busy = (count != '0);
    assign full = (count == MAX_OUTSTANDING);

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Command storage
    always_ff @(posedge core_clk) begin
        if (push) begin
            q[wr_ptr] <= cmd_in;
        end
    end

endmodule

`default_nettype wire

/* src/axi_sram_endpoint.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_sram_endpoint import axi_fabric_pkg::*; (
    input  logic        core_clk,
    input  logic        cptra_rst_b,
    input  logic        aw_valid,
    input  axi_cmd_t    aw,
    output logic        aw_ready,
    input  logic        w_valid,
    input  axi_w_beat_t w,
    output logic        w_ready,
    input  logic        b_ready,
    output logic        b_valid,
    output axi_b_resp_t b,
    input  logic        ar_valid,
    input  axi_cmd_t    ar,
    output logic        ar_ready,
    input  logic        r_ready,
    output logic        r_valid,
    output axi_r_beat_t r,
    output logic        r_busy,
    output logic        w_busy
);

    logic [DATA_W-1:0] mem [2**(SRAM_OFFS_W-2)];

    axi_cmd_t wr_head;
    axi_cmd_t rd_head;
    logic     wr_full;
    logic     rd_full;
    logic     w_fire;
    logic     b_fire;
    logic     r_fire;
    logic     r_done;
    logic     rd_issue;

    logic                   wr_inburst;
    logic [SRAM_OFFS_W-3:0] wr_word;
    logic [SRAM_OFFS_W-3:0] wr_addr;

    logic                   rd_inburst;
    logic [SRAM_OFFS_W-3:0] rd_word;
    logic [SRAM_OFFS_W-3:0] rd_addr;
    logic [LEN_W-1:0]       rd_cnt;
    logic [LEN_W-1:0]       rd_beat;

    // Window match through the SRAM view
    assign aw_ready = aw_valid && (aw.addr.sram.tag == SRAM_BASE_TAG) && !wr_full;
    assign ar_ready = ar_valid && (ar.addr.sram.tag == SRAM_BASE_TAG) && !rd_full;

    dma_txn_tracker u_wr_trk (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .push        (aw_ready),
        .cmd_in      (aw),
        .pop         (b_fire),
        .head        (wr_head),
        .busy        (w_busy),
        .full        (wr_full)
    );

    dma_txn_tracker u_rd_trk (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .push        (ar_ready),
        .cmd_in      (ar),
        .pop         (r_done),
        .head        (rd_head),
        .busy        (r_busy),
        .full        (rd_full)
    );

    // Write data goes to the head command until its B is taken
    assign w_ready = w_busy && !b_valid;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;
    assign wr_addr = wr_inburst ? wr_word : wr_head.addr.sram.offs[SRAM_OFFS_W-1:2];
    assign b       = '{id: wr_head.id, resp: RESP_OKAY};

    // Next beat once the output slot is free or drains this cycle
    assign r_fire   = r_valid && r_ready;
    assign r_done   = r_fire && r.last;
    assign rd_issue = r_busy && (!r_valid || (r_fire && !r.last));
    assign rd_addr  = rd_inburst ? rd_word : rd_head.addr.sram.offs[SRAM_OFFS_W-1:2];
    assign rd_beat  = rd_inburst ? rd_cnt : '0;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_inburst <= 1'b0;
            b_valid    <= 1'b0;
            rd_inburst <= 1'b0;
            r_valid    <= 1'b0;
        end else begin
            if (w_fire) begin
                wr_inburst <= !w.last;
            end
            if (w_fire && w.last) begin
                b_valid <= 1'b1;
            end else if (b_fire) begin
                b_valid <= 1'b0;
            end
            if (rd_issue) begin
                r_valid    <= 1'b1;
                rd_inburst <= (rd_beat != rd_head.len);
            end else if (r_fire) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Byte-strobed array, word stepping on INCR bursts
    always_ff @(posedge core_clk) begin
        if (w_fire) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_addr][i*8 +: 8] <= w.data[i*8 +: 8];
                end
            end
            wr_word <= (wr_head.burst == BURST_INCR) ? wr_addr + 1'b1 : wr_addr;
        end
        if (rd_issue) begin
            r.data  <= mem[rd_addr];
            r.id    <= rd_head.id;
            r.resp  <= RESP_OKAY;
            r.last  <= (rd_beat == rd_head.len);
            rd_word <= (rd_head.burst == BURST_INCR) ? rd_addr + 1'b1 : rd_addr;
            rd_cnt  <= rd_beat + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/axi_fifo_endpoint.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_fifo_endpoint import axi_fabric_pkg::*; (
    input  logic        core_clk,
    input  logic        cptra_rst_b,
    input  logic        aw_valid,
    input  axi_cmd_t    aw,
    output logic        aw_ready,
    input  logic        w_valid,
    input  axi_w_beat_t w,
    output logic        w_ready,
    input  logic        b_ready,
    output logic        b_valid,
    output axi_b_resp_t b,
    input  logic        ar_valid,
    input  axi_cmd_t    ar,
    output logic        ar_ready,
    input  logic        r_ready,
    output logic        r_valid,
    output axi_r_beat_t r,
    output logic        r_busy,
    output logic        w_busy
);

    logic [DATA_W-1:0] fifo_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rptr;
    logic [$clog2(FIFO_DEPTH):0]   fcount;
    logic                          fifo_full;
    logic                          fifo_empty;
    logic                          fifo_push;
    logic                          fifo_pop;
    logic                          drop;

    axi_cmd_t         wr_head;
    axi_cmd_t         rd_head;
    logic             wr_full;
    logic             rd_full;
    logic             w_fire;
    logic             b_fire;
    logic             w_err;
    logic             b_err;
    logic             r_fire;
    logic             r_done;
    logic             rd_issue;
    logic             rd_inburst;
    logic [LEN_W-1:0] rd_cnt;
    logic [LEN_W-1:0] rd_beat;

    // Window match through the FIFO view
    assign aw_ready = aw_valid && (aw.addr.fifo.tag == FIFO_BASE_TAG) && !wr_full;
    assign ar_ready = ar_valid && (ar.addr.fifo.tag == FIFO_BASE_TAG) && !rd_full;

    dma_txn_tracker u_wr_trk (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .push        (aw_ready),
        .cmd_in      (aw),
        .pop         (b_fire),
        .head        (wr_head),
        .busy        (w_busy),
        .full        (wr_full)
    );

    dma_txn_tracker u_rd_trk (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .push        (ar_ready),
        .cmd_in      (ar),
        .pop         (r_done),
        .head        (rd_head),
        .busy        (r_busy),
        .full        (rd_full)
    );

    assign fifo_full  = (fcount == FIFO_DEPTH);
    assign fifo_empty = (fcount == '0);

    assign w_ready   = w_busy && !b_valid;
    assign w_fire    = w_valid && w_ready;
    assign b_fire    = b_valid && b_ready;
    assign fifo_push = w_fire && !fifo_full;
    // Word lost on a full FIFO
    assign drop      = w_fire && fifo_full;
    assign b         = '{id: wr_head.id, resp: b_err ? RESP_SLVERR : RESP_OKAY};

    assign r_fire   = r_valid && r_ready;
    assign r_done   = r_fire && r.last;
    assign rd_issue = r_busy && (!r_valid || (r_fire && !r.last));
    assign rd_beat  = rd_inburst ? rd_cnt : '0;
    assign fifo_pop = rd_issue && !fifo_empty;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wptr       <= '0;
            rptr       <= '0;
            fcount     <= '0;
            w_err      <= 1'b0;
            b_err      <= 1'b0;
            b_valid    <= 1'b0;
            rd_inburst <= 1'b0;
            r_valid    <= 1'b0;
        end else begin
            if (fifo_push) begin
                wptr <= wptr + 1'b1;
            end
            if (fifo_pop) begin
                rptr <= rptr + 1'b1;
            end
            if (fifo_push && !fifo_pop) begin
                fcount <= fcount + 1'b1;
            end else if (fifo_pop && !fifo_push) begin
                fcount <= fcount - 1'b1;
            end

            // Overflow sticks until the burst ends
            if (w_fire) begin
                w_err <= w.last ? 1'b0 : (w_err || drop);
            end
            if (w_fire && w.last) begin
                b_valid <= 1'b1;
                b_err   <= w_err || drop;
            end else if (b_fire) begin
                b_valid <= 1'b0;
            end

            if (rd_issue) begin
                r_valid    <= 1'b1;
                rd_inburst <= (rd_beat != rd_head.len);
            end else if (r_fire) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Pop happens when the beat is loaded, held under back-pressure
    always_ff @(posedge core_clk) begin
        if (fifo_push) begin
            fifo_mem[wptr] <= w.data;
        end
        if (rd_issue) begin
            r.data <= fifo_empty ? '0 : fifo_mem[rptr];
            r.id   <= rd_head.id;
            r.resp <= fifo_empty ? RESP_SLVERR : RESP_OKAY;
            r.last <= (rd_beat == rd_head.len);
            rd_cnt <= rd_beat + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/axi_resp_mux.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_resp_mux import axi_fabric_pkg::*; (
    input  logic        sram_aw_ready,
    input  logic        sram_ar_ready,
    input  logic        sram_w_ready,
    input  logic        sram_b_valid,
    input  axi_b_resp_t sram_b,
    input  logic        sram_r_valid,
    input  axi_r_beat_t sram_r,
    input  logic        sram_r_busy,
    input  logic        sram_w_busy,
    input  logic        fifo_aw_ready,
    input  logic        fifo_ar_ready,
    input  logic        fifo_w_ready,
    input  logic        fifo_b_valid,
    input  axi_b_resp_t fifo_b,
    input  logic        fifo_r_valid,
    input  axi_r_beat_t fifo_r,
    input  logic        fifo_r_busy,
    input  logic        fifo_w_busy,
    output logic        aw_ready,
    output logic        ar_ready,
    output logic        w_ready,
    output logic        b_valid,
    output axi_b_resp_t b,
    output logic        r_valid,
    output axi_r_beat_t r
);

    // Only the matching window can raise its ready
    assign aw_ready = sram_aw_ready || fifo_aw_ready;
    assign ar_ready = sram_ar_ready || fifo_ar_ready;

    // Write side follows the endpoint with writes in flight
    always_comb begin
        if (sram_w_busy) begin
            w_ready = sram_w_ready;
            b_valid = sram_b_valid;
            b       = sram_b;
        end else if (fifo_w_busy) begin
            w_ready = fifo_w_ready;
            b_valid = fifo_b_valid;
            b       = fifo_b;
        end else begin
            w_ready = 1'b0;
            b_valid = 1'b0;
            b       = '0;
        end
    end

    always_comb begin
        if (sram_r_busy) begin
            r_valid = sram_r_valid;
            r       = sram_r;
        end else if (fifo_r_busy) begin
            r_valid = fifo_r_valid;
            r       = fifo_r;
        end else begin
            r_valid = 1'b0;
            r       = '0;
        end
    end

endmodule

`default_nettype wire

/* src/axi_dma_fabric.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_dma_fabric import axi_fabric_pkg::*; (
    input  logic        core_clk,
    input  logic        cptra_rst_b,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  axi_cmd_t    aw,
    input  logic        w_valid,
    output logic        w_ready,
    input  axi_w_beat_t w,
    output logic        b_valid,
    input  logic        b_ready,
    output axi_b_resp_t b,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  axi_cmd_t    ar,
    output logic        r_valid,
    input  logic        r_ready,
    output axi_r_beat_t r
);

    logic        sram_aw_ready;
    logic        sram_ar_ready;
    logic        sram_w_ready;
    logic        sram_b_valid;
    axi_b_resp_t sram_b;
    logic        sram_r_valid;
    axi_r_beat_t sram_r;
    logic        sram_r_busy;
    logic        sram_w_busy;

    logic        fifo_aw_ready;
    logic        fifo_ar_ready;
    logic        fifo_w_ready;
    logic        fifo_b_valid;
    axi_b_resp_t fifo_b;
    logic        fifo_r_valid;
    axi_r_beat_t fifo_r;
    logic        fifo_r_busy;
    logic        fifo_w_busy;

    // Manager requests are broadcast to both endpoints
    axi_sram_endpoint u_sram (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .aw_valid    (aw_valid),
        .aw          (aw),
        .aw_ready    (sram_aw_ready),
        .w_valid     (w_valid),
        .w           (w),
        .w_ready     (sram_w_ready),
        .b_ready     (b_ready),
        .b_valid     (sram_b_valid),
        .b           (sram_b),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .ar_ready    (sram_ar_ready),
        .r_ready     (r_ready),
        .r_valid     (sram_r_valid),
        .r           (sram_r),
        .r_busy      (sram_r_busy),
        .w_busy      (sram_w_busy)
    );

    axi_fifo_endpoint u_fifo (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .aw_valid    (aw_valid),
        .aw          (aw),
        .aw_ready    (fifo_aw_ready),
        .w_valid     (w_valid),
        .w           (w),
        .w_ready     (fifo_w_ready),
        .b_ready     (b_ready),
        .b_valid     (fifo_b_valid),
        .b           (fifo_b),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .ar_ready    (fifo_ar_ready),
        .r_ready     (r_ready),
        .r_valid     (fifo_r_valid),
        .r           (fifo_r),
        .r_busy      (fifo_r_busy),
        .w_busy      (fifo_w_busy)
    );

    axi_resp_mux u_mux (
        .sram_aw_ready (sram_aw_ready),
        .sram_ar_ready (sram_ar_ready),
        .sram_w_ready  (sram_w_ready),
        .sram_b_valid  (sram_b_valid),
        .sram_b        (sram_b),
        .sram_r_valid  (sram_r_valid),
        .sram_r        (sram_r),
        .sram_r_busy   (sram_r_busy),
        .sram_w_busy   (sram_w_busy),
        .fifo_aw_ready (fifo_aw_ready),
        .fifo_ar_ready (fifo_ar_ready),
        .fifo_w_ready  (fifo_w_ready),
        .fifo_b_valid  (fifo_b_valid),
        .fifo_b        (fifo_b),
        .fifo_r_valid  (fifo_r_valid),
        .fifo_r        (fifo_r),
        .fifo_r_busy   (fifo_r_busy),
        .fifo_w_busy   (fifo_w_busy),
        .aw_ready      (aw_ready),
        .ar_ready      (ar_ready),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b             (b),
        .r_valid       (r_valid),
        .r             (r)
    );

endmodule

`default_nettype wire

/* verif/axi_dma_fabric_tests.svh */
`ifndef AXI_DMA_FABRIC_TESTS_SVH
`define AXI_DMA_FABRIC_TESTS_SVH

localparam logic [ADDR_W-1:0] FIFO_ADDR     = 32'h0002_0000;
localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 32'h0003_0000;

// INCR write of a whole burst, B must be OKAY
task automatic sram_write(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                          input logic [DATA_W-1:0] data [$], input logic [STRB_W-1:0] strb);
    send_cmd(1'b0, make_cmd(id, addr, LEN_W'(data.size() - 1), BURST_INCR));
    send_w_burst(data, strb);
    for (int i = 0; i < data.size(); i++) begin
        model_sram_write(int'(addr[SRAM_OFFS_W-1:2]) + i, data[i], strb);
    end
    recv_b(make_b(id, RESP_OKAY), "b");
endtask

task automatic sram_read_check(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                               input int beats);
    send_cmd(1'b1, make_cmd(id, addr, LEN_W'(beats - 1), BURST_INCR));
    for (int i = 0; i < beats; i++) begin
        recv_r(make_r(sram_model[int'(addr[SRAM_OFFS_W-1:2]) + i], id, RESP_OKAY,
                      i == beats - 1), "r");
    end
endtask

// Words beyond the FIFO depth are lost and flag the burst
task automatic fifo_push_burst(input logic [ID_W-1:0] id, input int beats);
    logic [DATA_W-1:0] data [$];
    logic [1:0]        exp_resp;
    exp_resp = RESP_OKAY;
    for (int i = 0; i < beats; i++) begin
        data.push_back($random(seed));
    end
    send_cmd(1'b0, make_cmd(id, FIFO_ADDR, LEN_W'(beats - 1), BURST_FIXED));
    // Strobes are ignored by the FIFO
    send_w_burst(data, 4'h1);
    for (int i = 0; i < beats; i++) begin
        if (fifo_model.size() < FIFO_DEPTH) begin
            fifo_model.push_back(data[i]);
        end else begin
            exp_resp = RESP_SLVERR;
        end
    end
    recv_b(make_b(id, exp_resp), "b");
endtask

task automatic fifo_pop_burst(input logic [ID_W-1:0] id, input int beats);
    axi_r_beat_t exp;
    send_cmd(1'b1, make_cmd(id, FIFO_ADDR, LEN_W'(beats - 1), BURST_FIXED));
    for (int i = 0; i < beats; i++) begin
        if (fifo_model.size() > 0) begin
            exp = make_r(fifo_model.pop_front(), id, RESP_OKAY, i == beats - 1);
        end else begin
            exp = make_r('0, id, RESP_SLVERR, i == beats - 1);
        end
        recv_r(exp, "r");
    end
endtask

task automatic sram_incr_burst();
    logic [DATA_W-1:0] data [$];
    $display("Test: SRAM INCR burst");
    for (int i = 0; i < 4; i++) begin
        data.push_back($random(seed));
    end
    sram_write(32'h0001_0040, 4'h6, data, 4'hF);
    sram_read_check(32'h0001_0040, 4'h6, 4);
endtask

task automatic sram_byte_strobes();
    logic [DATA_W-1:0] data [$];
    $display("Test: SRAM byte strobes");
    data.push_back($random(seed));
    sram_write(32'h0001_0100, 4'h2, data, 4'hF);
    // Bytes 0 and 2 only
    data[0] = $random(seed);
    sram_write(32'h0001_0100, 4'h2, data, 4'b0101);
    sram_read_check(32'h0001_0100, 4'h2, 1);
endtask

task automatic fifo_order();
    $display("Test: FIFO order and empty read");
    fifo_push_burst(4'h2, 3);
    fifo_pop_burst(4'h2, 3);
    fifo_pop_burst(4'h2, 1);
endtask

task automatic fifo_overflow();
    $display("Test: FIFO overflow");
    fifo_push_burst(4'h9, FIFO_DEPTH + 1);
    fifo_pop_burst(4'h9, FIFO_DEPTH);
endtask

task automatic read_backpressure();
    axi_r_beat_t first_beat;
    int          stall;
    $display("Test: outstanding SRAM reads under back-pressure");
    r_ready = 1'b0;
    send_cmd(1'b1, make_cmd(4'h3, 32'h0001_0040, 8'd1, BURST_INCR));
    send_cmd(1'b1, make_cmd(4'h5, 32'h0001_0048, 8'd1, BURST_INCR));
    // Both tracker slots taken, so a third read waits
    ar       = make_cmd(4'h7, 32'h0001_0040, 8'd0, BURST_INCR);
    ar_valid = 1'b1;
    settle();
    check_bit("ar_ready", 1'b0, ar_ready);
    @(negedge core_clk);
    ar_valid = 1'b0;
    // First beat of id 3 must hold while stalled
    first_beat = make_r(sram_model[16], 4'h3, RESP_OKAY, 1'b0);
    wait_for_r_valid();
    check_r("r", first_beat, r);
    stall = 3 + ({$random(seed)} % 6);
    for (int i = 0; i < stall; i++) begin
        @(negedge core_clk);
        settle();
        check_bit("r_valid", 1'b1, r_valid);
        check_r("r", first_beat, r);
    end
    @(negedge core_clk);
    for (int i = 0; i < 2; i++) begin
        recv_r(make_r(sram_model[16 + i], 4'h3, RESP_OKAY, i == 1), "r");
    end
    for (int i = 0; i < 2; i++) begin
        recv_r(make_r(sram_model[18 + i], 4'h5, RESP_OKAY, i == 1), "r");
    end
endtask

task automatic unmapped_read();
    $display("Test: unmapped read address");
    ar       = make_cmd(4'h1, UNMAPPED_ADDR, 8'd0, BURST_INCR);
    ar_valid = 1'b1;
    for (int i = 0; i < 20; i++) begin
        settle();
        check_bit("ar_ready", 1'b0, ar_ready);
        @(negedge core_clk);
    end
    ar_valid = 1'b0;
    settle();
    check_bit("r_valid", 1'b0, r_valid);
    @(negedge core_clk);
endtask

`endif

/* verif/axi_dma_fabric_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module axi_dma_fabric_tb
    import axi_fabric_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 200;

    logic        core_clk;
    logic        cptra_rst_b;
    logic        aw_valid;
    logic        aw_ready;
    axi_cmd_t    aw;
    logic        w_valid;
    logic        w_ready;
    axi_w_beat_t w;
    logic        b_valid;
    logic        b_ready;
    axi_b_resp_t b;
    logic        ar_valid;
    logic        ar_ready;
    axi_cmd_t    ar;
    logic        r_valid;
    logic        r_ready;
    axi_r_beat_t r;

    int     n_checks;
    int     n_errors;
    integer seed;

    // Reference contents of the SRAM window and the FIFO
    logic [DATA_W-1:0] sram_model [2**(SRAM_OFFS_W-2)];
    logic [DATA_W-1:0] fifo_model [$];

    initial core_clk = 1'b0;
    always #(CLK_PERIOD/2) core_clk = ~core_clk;

    axi_dma_fabric u_dut (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw          (aw),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w           (w),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b           (b),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r)
    );

    task automatic check_r(input string name, input axi_r_beat_t exp, input axi_r_beat_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $write("[ERROR] t=%0t %s: expected data=%h id=%h resp=%b last=%b",
                   $time, name, exp.data, exp.id, exp.resp, exp.last);
            $display(" got data=%h id=%h resp=%b last=%b",
                     got.data, got.id, got.resp, got.last);
        end
    endtask

    task automatic check_b(input string name, input axi_b_resp_t exp, input axi_b_resp_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s: expected id=%h resp=%b got id=%h resp=%b",
                     $time, name, exp.id, exp.resp, got.id, got.resp);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s: expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        n_errors++;
        $display("Gave up after %0d cycles waiting for %s", WAIT_LIMIT, what);
        finish_run();
    endtask

    // Outputs are stable a quarter period after the falling edge
    task automatic settle();
        #(CLK_PERIOD/4);
    endtask

    function automatic axi_cmd_t make_cmd(input logic [ID_W-1:0] id,
                                          input logic [ADDR_W-1:0] addr,
                                          input logic [LEN_W-1:0] len,
                                          input logic [1:0] burst);
        axi_cmd_t cmd;
        cmd.id    = id;
        cmd.addr  = addr;
        cmd.len   = len;
        cmd.burst = burst;
        return cmd;
    endfunction

    function automatic axi_r_beat_t make_r(input logic [DATA_W-1:0] data,
                                           input logic [ID_W-1:0] id,
                                           input logic [1:0] resp,
                                           input logic last);
        axi_r_beat_t beat;
        beat.data = data;
        beat.id   = id;
        beat.resp = resp;
        beat.last = last;
        return beat;
    endfunction

    function automatic axi_b_resp_t make_b(input logic [ID_W-1:0] id, input logic [1:0] resp);
        axi_b_resp_t rsp;
        rsp.id   = id;
        rsp.resp = resp;
        return rsp;
    endfunction

    function automatic void model_sram_write(input int word,
                                             input logic [DATA_W-1:0] data,
                                             input logic [STRB_W-1:0] strb);
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                sram_model[word][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endfunction

    // Drives AW or AR until accepted, returns on the next falling edge
    task automatic send_cmd(input logic is_read, input axi_cmd_t cmd);
        int cycles;
        cycles = 0;
        if (is_read) begin
            ar       = cmd;
            ar_valid = 1'b1;
        end else begin
            aw       = cmd;
            aw_valid = 1'b1;
        end
        settle();
        while (!(is_read ? ar_ready : aw_ready)) begin
            if (cycles == WAIT_LIMIT) begin
                abort_on_timeout(is_read ? "ar_ready" : "aw_ready");
            end
            @(negedge core_clk);
            settle();
            cycles++;
        end
        @(negedge core_clk);
        ar_valid = 1'b0;
        aw_valid = 1'b0;
    endtask

    task automatic send_w_burst(input logic [DATA_W-1:0] data [$],
                                input logic [STRB_W-1:0] strb);
        int cycles;
        for (int i = 0; i < data.size(); i++) begin
            w.data  = data[i];
            w.strb  = strb;
            w.last  = (i == data.size() - 1);
            w_valid = 1'b1;
            cycles  = 0;
            settle();
            while (!w_ready) begin
                if (cycles == WAIT_LIMIT) begin
                    abort_on_timeout("w_ready");
                end
                @(negedge core_clk);
                settle();
                cycles++;
            end
            @(negedge core_clk);
        end
        w_valid = 1'b0;
    endtask

    task automatic recv_b(input axi_b_resp_t exp, input string name);
        int cycles;
        cycles  = 0;
        b_ready = 1'b1;
        settle();
        while (!b_valid) begin
            if (cycles == WAIT_LIMIT) begin
                abort_on_timeout("b_valid");
            end
            @(negedge core_clk);
            settle();
            cycles++;
        end
        check_b(name, exp, b);
        @(negedge core_clk);
        b_ready = 1'b0;
    endtask

    task automatic wait_for_r_valid();
        int cycles;
        cycles = 0;
        settle();
        while (!r_valid) begin
            if (cycles == WAIT_LIMIT) begin
                abort_on_timeout("r_valid");
            end
            @(negedge core_clk);
            settle();
            cycles++;
        end
    endtask

    task automatic recv_r(input axi_r_beat_t exp, input string name);
        r_ready = 1'b1;
        wait_for_r_valid();
        check_r(name, exp, r);
        @(negedge core_clk);
        r_ready = 1'b0;
    endtask

    `include "axi_dma_fabric_tests.svh"

    initial begin
        seed        = 86210;
        n_checks    = 0;
        n_errors    = 0;
        cptra_rst_b = 1'b0;
        aw_valid    = 1'b0;
        aw          = '0;
        w_valid     = 1'b0;
        w           = '0;
        b_ready     = 1'b0;
        ar_valid    = 1'b0;
        ar          = '0;
        r_ready     = 1'b0;
        repeat (RESET_CYCLES) @(negedge core_clk);
        cptra_rst_b = 1'b1;
        @(negedge core_clk);
        settle();
        // Idle port after reset
        check_bit("aw_ready", 1'b0, aw_ready);
        check_bit("ar_ready", 1'b0, ar_ready);
        check_bit("w_ready", 1'b0, w_ready);
        check_bit("b_valid", 1'b0, b_valid);
        check_bit("r_valid", 1'b0, r_valid);
        @(negedge core_clk);

        sram_incr_burst();
        sram_byte_strobes();
        fifo_order();
        fifo_overflow();
        read_backpressure();
        unmapped_read();
        finish_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
src/axi_fabric_pkg.sv
src/dma_txn_tracker.sv
src/axi_sram_endpoint.sv
src/axi_fifo_endpoint.sv
src/axi_resp_mux.sv
src/axi_dma_fabric.sv
verif/axi_dma_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fabric testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module axi_dma_fabric_tb \
    -f vlog.f -Mdir obj_dir -o sim_axi_dma_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_axi_dma_fabric > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
